//--- verilog/mbu_pkg.sv
// Memory bank unit shared definitions: unit codes, widths and disabled-state defaults

package mbu_pkg;

   ////////////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////////////

   localparam int DATA_W = 8;                // Bus and bank register width
   localparam int SLOT_W = 3;                // Eight slots per context

   typedef logic [DATA_W-1:0] mbu_data_t;    // One bus byte
   typedef logic [SLOT_W-1:0] mbu_slot_t;    // Slot inside a context

   // Microcode read or write unit code
   typedef logic [4:0] mbu_unit_t;

   ////////////////////////////////////////////////////////////////////
   // Unit codes
   ////////////////////////////////////////////////////////////////////

   localparam mbu_unit_t UNIT_MBN   = 5'b11011;   // Bank register picked by ir
   localparam mbu_unit_t UNIT_MBP   = 5'b11100;   // Bank register 0
   localparam mbu_unit_t UNIT_CTX_A = 5'b11101;   // Context register
   localparam mbu_unit_t UNIT_CTX_B = 5'b11110;   // Context register, second code

   // Prefix of the four write-AR codes on waddr
   localparam logic [2:0] AR_GROUP = 3'b001;

   // MBP lives in slot 0 of every context
   localparam mbu_slot_t SLOT_MBP = '0;

   // One unit word, seen either as a whole code or as group plus index.
   // The low two bits of raddr select the slot in index mode.
   typedef union packed {
      mbu_unit_t code;          // Compared against UNIT_*
      struct packed {
         logic [2:0] group;     // AR_GROUP on write-AR
         logic [1:0] idx;       // Index slot
      } ar;
   } mbu_unit_u;

   ////////////////////////////////////////////////////////////////////
   // Disabled-state extended address
   ////////////////////////////////////////////////////////////////////

   // Until the first MBn write the AR sees a fixed page.
   // The front panel switch picks the ROM page or the RAM page.
   localparam mbu_data_t AEXT_DEF_RAM = 8'h00;    // Switch clear
   localparam mbu_data_t AEXT_DEF_ROM = 8'h80;    // Switch set

endpackage

//--- verilog/mbu_if.sv
// Memory bank unit stage links: decoded commands and bank accesses

// Decoder to control stage
interface mbu_cmd_if;
   import mbu_pkg::*;

   logic       rd_mbn;      // MBn onto the bus
   logic       rd_mbp;      // MBP onto the bus
   logic       rd_ctx;      // CTX onto the bus
   logic       wr_mbn;      // Bus into MBn
   logic       wr_mbp;      // Bus into MBP
   logic       wr_ctx;      // Bus into CTX
   logic       war;         // Write-AR, drive aext
   logic       idx_use;     // Write-AR takes slot from raddr_idx
   mbu_slot_t  ir_slot;     // ir[2:0]
   logic [1:0] raddr_idx;   // raddr[1:0]
   mbu_data_t  data;        // Bus value for writes

   modport src (
      output rd_mbn, rd_mbp, rd_ctx, wr_mbn, wr_mbp, wr_ctx, war, idx_use,
      output ir_slot, raddr_idx, data
   );

   modport dst (
      input  rd_mbn, rd_mbp, rd_ctx, wr_mbn, wr_mbp, wr_ctx, war, idx_use,
      input  ir_slot, raddr_idx, data
   );
endinterface

// Control stage to bank file
interface mbu_acc_if;
   import mbu_pkg::*;

   logic      rd_mb;        // Bank slot onto the bus
   logic      wr_mb;        // Bus into bank slot
   logic      enable_set;   // MBn write, leave disabled state
   logic      rd_ctx;       // CTX onto the bus
   logic      wr_ctx;       // Bus into CTX
   logic      war;          // Bank slot onto aext
   mbu_slot_t slot;         // Granted slot
   mbu_data_t data;         // Write value

   modport src (output rd_mb, wr_mb, enable_set, rd_ctx, wr_ctx, war, slot, data);
   modport dst (input  rd_mb, wr_mb, enable_set, rd_ctx, wr_ctx, war, slot, data);
endinterface

//--- verilog/mbu_decoder.sv
// Memory bank unit stage 1, decodes the unit codes and tracks index mode

module mbu_decoder (
   input  logic               clk4,      // Processor clock
   input  logic               rst_n,
   input  mbu_pkg::mbu_unit_t raddr,     // Read unit code
   input  mbu_pkg::mbu_unit_t waddr,     // Write unit code
   input  mbu_pkg::mbu_data_t ibus_in,   // Internal bus
   input  mbu_pkg::mbu_slot_t ir,        // Slot field of the instruction
   input  logic               ir_idx,    // Arm index mode
   mbu_cmd_if.src             cmd
);
   import mbu_pkg::*;

   mbu_unit_u r_u;        // raddr, both views
   mbu_unit_u w_u;        // waddr, both views
   logic      rd_mbn_c;
   logic      rd_mbp_c;
   logic      rd_ctx_c;
   logic      wr_mbn_c;
   logic      wr_mbp_c;
   logic      wr_ctx_c;
   logic      war_c;
   logic      idx_use_c;
   logic      idx_q;      // Index mode armed

   assign r_u = raddr;
   assign w_u = waddr;

   ////////////////////////////////////////////////////////////////////
   // Code compare
   ////////////////////////////////////////////////////////////////////

   assign rd_mbn_c = (r_u.code == UNIT_MBN);
   assign rd_mbp_c = (r_u.code == UNIT_MBP);
   assign rd_ctx_c = (r_u.code == UNIT_CTX_A) || (r_u.code == UNIT_CTX_B);

   assign wr_mbn_c = (w_u.code == UNIT_MBN);
   assign wr_mbp_c = (w_u.code == UNIT_MBP);
   assign wr_ctx_c = (w_u.code == UNIT_CTX_A) || (w_u.code == UNIT_CTX_B);

   assign war_c    = (w_u.ar.group == AR_GROUP);   // Any of the four AR codes

   // Strobe in the same cycle counts too
   assign idx_use_c = war_c && (idx_q || ir_idx);

   ////////////////////////////////////////////////////////////////////
   // Registers
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk4 or negedge rst_n) begin
      if (!rst_n) begin
         cmd.rd_mbn  <= 1'b0;
         cmd.rd_mbp  <= 1'b0;
         cmd.rd_ctx  <= 1'b0;
         cmd.wr_mbn  <= 1'b0;
         cmd.wr_mbp  <= 1'b0;
         cmd.wr_ctx  <= 1'b0;
         cmd.war     <= 1'b0;
         cmd.idx_use <= 1'b0;
         idx_q       <= 1'b0;
      end else begin
         cmd.rd_mbn  <= rd_mbn_c;
         cmd.rd_mbp  <= rd_mbp_c;
         cmd.rd_ctx  <= rd_ctx_c;
         cmd.wr_mbn  <= wr_mbn_c;
         cmd.wr_mbp  <= wr_mbp_c;
         cmd.wr_ctx  <= wr_ctx_c;
         cmd.war     <= war_c;
         cmd.idx_use <= idx_use_c;
         idx_q       <= war_c ? 1'b0 : (idx_q | ir_idx);   // Next write-AR consumes it
      end
   end

   // Operands ride along with the flags
   always_ff @(posedge clk4) begin
      cmd.ir_slot   <= ir;
      cmd.raddr_idx <= r_u.ar.idx;
      cmd.data      <= ibus_in;
   end

endmodule

//--- verilog/mbu_control.sv
// Memory bank unit stage 2, maps decoded commands onto one bank access

module mbu_control #(
   parameter int CTX_W = 8     // Context width, bank file concern only
) (
   input  logic   clk4,
   input  logic   rst_n,
   mbu_cmd_if.dst cmd,         // Flags from the decoder
   mbu_acc_if.src acc          // Access to the 2**CTX_W context bank file
);
   import mbu_pkg::*;

   logic      wr_any;     // MBn or MBP write
   logic      rd_any;     // MBn or MBP bus read
   logic      rd_ok;      // Bus read won the slot
   mbu_slot_t wr_slot;
   mbu_slot_t rd_slot;
   mbu_slot_t war_slot;
   mbu_slot_t slot_c;     // Granted slot

   ////////////////////////////////////////////////////////////////////
   // Slot selection
   ////////////////////////////////////////////////////////////////////

   assign wr_any  = cmd.wr_mbn | cmd.wr_mbp;
   assign rd_any  = cmd.rd_mbn | cmd.rd_mbp;

   assign wr_slot  = cmd.wr_mbn  ? cmd.ir_slot : SLOT_MBP;
   assign rd_slot  = cmd.rd_mbn  ? cmd.ir_slot : SLOT_MBP;
   assign war_slot = cmd.idx_use ? mbu_slot_t'(cmd.raddr_idx) : cmd.ir_slot;

   // Bank has one address. A write never meets a write-AR (both are waddr
   // codes), so the order is write, then write-AR, then bus read.
   always_comb begin
      if (wr_any)
         slot_c = wr_slot;
      else if (cmd.war)
         slot_c = war_slot;
      else
         slot_c = rd_slot;
   end

   // Bus read on another slot loses and is dropped
   assign rd_ok = rd_any && (rd_slot == slot_c);

   ////////////////////////////////////////////////////////////////////
   // Access register
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk4 or negedge rst_n) begin
      if (!rst_n) begin
         acc.rd_mb      <= 1'b0;
         acc.wr_mb      <= 1'b0;
         acc.enable_set <= 1'b0;
         acc.rd_ctx     <= 1'b0;
         acc.wr_ctx     <= 1'b0;
         acc.war        <= 1'b0;
      end else begin
         acc.rd_mb      <= rd_ok;
         acc.wr_mb      <= wr_any;
         acc.enable_set <= cmd.wr_mbn;     // First MBn write turns the unit on
         acc.rd_ctx     <= cmd.rd_ctx;
         acc.wr_ctx     <= cmd.wr_ctx;
         acc.war        <= cmd.war;
      end
   end

   always_ff @(posedge clk4) begin
      acc.slot <= slot_c;
      acc.data <= cmd.data;
   end

endmodule

//--- verilog/mbu_bank_file.sv
// Memory bank unit stage 3, context register, enable flag and bank memory

module mbu_bank_file #(
   parameter int CTX_W = 8                 // Context register width
) (
   input  logic               clk4,
   input  logic               rst_n,
   input  logic               fp_rom,      // Front panel ROM switch
   mbu_acc_if.dst             acc,
   output mbu_pkg::mbu_data_t ibus_out,    // Bus value, valid with ibus_oe
   output logic               ibus_oe,     // Bus drive strobe
   output mbu_pkg::mbu_data_t aext,        // Extended address, valid with war
   output logic               war          // AR load strobe
);
   import mbu_pkg::*;

   localparam int ADDR_W = CTX_W + SLOT_W;   // CTX then slot
   localparam int DEPTH  = 2 ** ADDR_W;

   logic [CTX_W-1:0]  ctx_q;      // Current context
   logic              en_q;       // Unit enabled
   logic [ADDR_W-1:0] addr;       // Bank word address
   logic              mem_we;
   mbu_data_t         mem_rd;     // Old contents at addr
   mbu_data_t         aext_c;
   mbu_data_t         mem [DEPTH];

   ////////////////////////////////////////////////////////////////////
   // Bank memory
   ////////////////////////////////////////////////////////////////////

   assign addr   = {ctx_q, acc.slot};
   assign mem_rd = mem[addr];              // Async read, sampled before the write lands

   // MBP writes need the unit on, MBn writes turn it on themselves
   assign mem_we = acc.wr_mb && (en_q || acc.enable_set);

   always_ff @(posedge clk4) begin
      if (mem_we)
         mem[addr] <= acc.data;
   end

   ////////////////////////////////////////////////////////////////////
   // Context and enable
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk4 or negedge rst_n) begin
      if (!rst_n) begin
         ctx_q <= '0;
         en_q  <= 1'b0;
      end else begin
         if (acc.wr_ctx)
            ctx_q <= CTX_W'(acc.data);     // Low bits of the bus
         if (acc.enable_set)
            en_q  <= 1'b1;                  // Stays on until reset
      end
   end

   // Page default until enabled
   always_comb begin
      if (en_q)
         aext_c = mem_rd;
      else if (fp_rom)
         aext_c = AEXT_DEF_ROM;
      else
         aext_c = AEXT_DEF_RAM;
   end

   ////////////////////////////////////////////////////////////////////
   // Output registers
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk4 or negedge rst_n) begin
      if (!rst_n) begin
         ibus_oe  <= 1'b0;
         ibus_out <= '0;
         war      <= 1'b0;
         aext     <= '0;
      end else begin
         // CTX always answers, bank slots only once enabled
         ibus_oe <= acc.rd_ctx || (acc.rd_mb && en_q);
         if (acc.rd_ctx)
            ibus_out <= mbu_data_t'(ctx_q);   // Upper bits read as zero
         else if (acc.rd_mb)
            ibus_out <= mem_rd;
         war <= acc.war;
         if (acc.war)
            aext <= aext_c;
      end
   end

endmodule

//--- verilog/mbu.sv
// Memory bank unit top, three registered stages from unit codes to bus and AR

module mbu #(
   parameter int CTX_W = 8                 // Context register width
) (
   input  logic               clk4,        // Processor clock
   input  logic               rst_n,
   input  mbu_pkg::mbu_unit_t raddr,       // Microcode read unit
   input  mbu_pkg::mbu_unit_t waddr,       // Microcode write unit
   input  mbu_pkg::mbu_data_t ibus_in,     // Internal bus, low byte
   input  mbu_pkg::mbu_slot_t ir,          // ir[2:0]
   input  logic               ir_idx,      // Index mode strobe
   input  logic               fp_rom,      // Front panel ROM switch
   output mbu_pkg::mbu_data_t ibus_out,
   output logic               ibus_oe,     // Bus drive enable
   output mbu_pkg::mbu_data_t aext,        // Extended address to the AR
   output logic               war          // Write-AR strobe
);

   mbu_cmd_if cmd ();    // Stage 1 to stage 2
   mbu_acc_if acc ();    // Stage 2 to stage 3

   ////////////////////////////////////////////////////////////////////
   // Stage 1, decode
   ////////////////////////////////////////////////////////////////////

   mbu_decoder u_decoder (
      .clk4    (clk4),
      .rst_n   (rst_n),
      .raddr   (raddr),
      .waddr   (waddr),
      .ibus_in (ibus_in),
      .ir      (ir),
      .ir_idx  (ir_idx),
      .cmd     (cmd.src)
   );

   ////////////////////////////////////////////////////////////////////
   // Stage 2, slot and arbitration
   ////////////////////////////////////////////////////////////////////

   mbu_control #(
      .CTX_W (CTX_W)
   ) u_control (
      .clk4  (clk4),
      .rst_n (rst_n),
      .cmd   (cmd.dst),
      .acc   (acc.src)
   );

   ////////////////////////////////////////////////////////////////////
   // Stage 3, bank access and outputs
   ////////////////////////////////////////////////////////////////////

   mbu_bank_file #(
      .CTX_W (CTX_W)
   ) u_bank_file (
      .clk4     (clk4),
      .rst_n    (rst_n),
      .fp_rom   (fp_rom),
      .acc      (acc.dst),
      .ibus_out (ibus_out),
      .ibus_oe  (ibus_oe),
      .aext     (aext),
      .war      (war)
   );

endmodule

//--- tests/mbu_model.svh
// Memory bank unit reference model, CTX, enable, index mode and bank contents
`ifndef MBU_MODEL_SVH
`define MBU_MODEL_SVH

// Expected outputs of one command, seen three cycles later
typedef struct packed {
   logic      oe;         // ibus_oe
   logic      bus_ok;     // Bus value known
   mbu_data_t bus;
   logic      war;
   logic      aext_ok;    // Extended address known
   mbu_data_t aext;
} expect_t;

localparam int BANK_WORDS = 2 ** (CTX_W + 3);   // Eight slots per context

logic [CTX_W-1:0] ctx_m;                  // Context register
logic             en_m;                   // Unit enabled
logic             idx_m;                  // Index mode armed
mbu_data_t        bank_m [BANK_WORDS];
bit               set_m  [BANK_WORDS];    // Written since reset

task automatic reset_model();
   int i;
   ctx_m = '0;
   en_m  = 1'b0;
   idx_m = 1'b0;
   for (i = 0; i < BANK_WORDS; i++) begin
      bank_m[i] = '0;
      set_m[i]  = 1'b0;
   end
endtask

// One command pair: results first from the old state, then the update
task automatic step_model(input mbu_unit_t ra, input mbu_unit_t wa, input mbu_data_t d,
                          input mbu_slot_t s, input logic strobe, input logic rom,
                          output expect_t e);
   logic             rd_mbn, rd_mbp, rd_ctx;
   logic             wr_mbn, wr_mbp, wr_ctx;
   logic             ar_hit, idx_now, rd_lost;
   mbu_slot_t        rd_slot, wr_slot, ar_slot;
   logic [CTX_W+2:0] rd_addr, wr_addr, ar_addr;
   rd_mbn  = (ra == UNIT_MBN);
   rd_mbp  = (ra == UNIT_MBP);
   rd_ctx  = (ra == UNIT_CTX_A) || (ra == UNIT_CTX_B);
   wr_mbn  = (wa == UNIT_MBN);
   wr_mbp  = (wa == UNIT_MBP);
   wr_ctx  = (wa == UNIT_CTX_A) || (wa == UNIT_CTX_B);
   ar_hit  = (wa[4:2] == AR_GROUP);
   idx_now = idx_m || strobe;                            // Same-cycle strobe counts
   rd_slot = rd_mbn ? s : 3'd0;                          // MBP is slot 0
   wr_slot = wr_mbn ? s : 3'd0;
   ar_slot = (ar_hit && idx_now) ? {1'b0, ra[1:0]} : s;
   rd_addr = {ctx_m, rd_slot};
   wr_addr = {ctx_m, wr_slot};
   ar_addr = {ctx_m, ar_slot};
   // One bank address per cycle, a bus read on another slot gets nothing
   rd_lost = (wr_mbn || wr_mbp) ? (wr_slot != rd_slot) : (ar_hit && (ar_slot != rd_slot));
   e = '0;
   if (rd_ctx) begin
      e.oe     = 1'b1;
      e.bus_ok = 1'b1;
      e.bus    = mbu_data_t'(ctx_m);
   end else if ((rd_mbn || rd_mbp) && !rd_lost && en_m) begin
      e.oe     = 1'b1;
      e.bus_ok = set_m[rd_addr];
      e.bus    = bank_m[rd_addr];
   end
   if (ar_hit) begin
      e.war     = 1'b1;
      e.aext_ok = en_m ? set_m[ar_addr] : 1'b1;
      e.aext    = en_m ? bank_m[ar_addr] : (rom ? 8'h80 : 8'h00);
   end
   idx_m = ar_hit ? 1'b0 : idx_now;                      // Used up by one write-AR
   if (wr_mbn || (wr_mbp && en_m)) begin
      bank_m[wr_addr] = d;
      set_m[wr_addr]  = 1'b1;
   end
   if (wr_mbn)
      en_m = 1'b1;
   if (wr_ctx)
      ctx_m = d[CTX_W-1:0];
endtask

`endif

//--- tests/tb_mbu.sv
// Memory bank unit testbench, directed and random commands against a reference model

module tb_mbu;
   import mbu_pkg::*;

   localparam int CTX_W      = 8;
   localparam int NUM_CYCLES = 3000;                     // Commands in the run
   localparam int WATCHDOG   = (NUM_CYCLES + 50) * 10;   // Time limit

   localparam mbu_unit_t NONE  = 5'b00000;               // Matches no unit
   localparam mbu_unit_t AR_0  = {AR_GROUP, 2'b00};
   localparam mbu_unit_t AR_1  = {AR_GROUP, 2'b01};
   localparam mbu_unit_t IDX_2 = 5'b00010;               // Index 2 on raddr, no read

   logic      clk4;
   logic      rst_n;
   mbu_unit_t raddr;
   mbu_unit_t waddr;
   mbu_data_t ibus_in;
   mbu_slot_t ir;
   logic      ir_idx;
   logic      fp_rom;
   mbu_data_t ibus_out;
   logic      ibus_oe;
   mbu_data_t aext;
   logic      war;

   `include "mbu_model.svh"

   expect_t exp_q [$];    // Delay line, three commands deep
   int      cyc;
   int      err_rst;
   int      err_oe;
   int      err_bus;
   int      err_war;
   int      err_aext;

   mbu #(.CTX_W(CTX_W)) u_mbu (
      .clk4(clk4), .rst_n(rst_n), .raddr(raddr), .waddr(waddr), .ibus_in(ibus_in),
      .ir(ir), .ir_idx(ir_idx), .fp_rom(fp_rom), .ibus_out(ibus_out), .ibus_oe(ibus_oe),
      .aext(aext), .war(war)
   );

   initial begin
      clk4 = 1'b0;
      forever #5 clk4 = ~clk4;
   end

   initial begin
      #(WATCHDOG);
      $display("Run timed out before all commands were checked");
      $display("Simulation failed");
      $finish;
   end

   //////////////////////////////////////////////////////////////////////
   // Tasks
   //////////////////////////////////////////////////////////////////////

   task automatic check_result(input expect_t e);
      assert (ibus_oe === e.oe) else begin
         err_oe++;
         $display("ERR %0t ibus_oe expected %0b actual %0b", $time, e.oe, ibus_oe);
      end
      assert (!(e.oe && e.bus_ok) || (ibus_out === e.bus)) else begin
         err_bus++;
         $display("ERR %0t ibus_out expected %02h actual %02h", $time, e.bus, ibus_out);
      end
      assert (war === e.war) else begin
         err_war++;
         $display("ERR %0t war expected %0b actual %0b", $time, e.war, war);
      end
      assert (!(e.war && e.aext_ok) || (aext === e.aext)) else begin
         err_aext++;
         $display("ERR %0t aext expected %02h actual %02h", $time, e.aext, aext);
      end
   endtask

   // Check the result due now, then drive the next command 1 unit past the edge
   task automatic apply_cmd(input mbu_unit_t ra, input mbu_unit_t wa, input mbu_data_t d,
                            input mbu_slot_t s, input logic strobe);
      expect_t e;
      @(posedge clk4);
      #1;
      if (exp_q.size() >= 3)
         check_result(exp_q.pop_front());
      raddr   = ra;
      waddr   = wa;
      ibus_in = d;
      ir      = s;
      ir_idx  = strobe;
      step_model(ra, wa, d, s, strobe, fp_rom, e);
      exp_q.push_back(e);
      cyc++;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) apply_cmd(NONE, NONE, '0, '0, 1'b0);
   endtask

   // Weighted toward MBU and AR codes, CTX kept to 0..3 so banks repeat
   task automatic random_cmd();
      int        pick;
      mbu_unit_t ra;
      mbu_unit_t wa;
      mbu_data_t d;
      pick = $urandom_range(0, 99);
      if (pick < 35)      ra = UNIT_MBN;
      else if (pick < 50) ra = UNIT_MBP;
      else if (pick < 58) ra = UNIT_CTX_A;
      else if (pick < 65) ra = UNIT_CTX_B;
      else                ra = mbu_unit_t'($urandom_range(0, 31));
      pick = $urandom_range(0, 99);
      if (pick < 25)      wa = UNIT_MBN;
      else if (pick < 40) wa = UNIT_MBP;
      else if (pick < 47) wa = UNIT_CTX_A;
      else if (pick < 52) wa = UNIT_CTX_B;
      else if (pick < 80) wa = {AR_GROUP, 2'($urandom_range(0, 3))};
      else                wa = mbu_unit_t'($urandom_range(0, 31));
      if (wa == UNIT_CTX_A || wa == UNIT_CTX_B)
         d = mbu_data_t'($urandom_range(0, 3));
      else
         d = mbu_data_t'($urandom_range(0, 255));
      apply_cmd(ra, wa, d, mbu_slot_t'($urandom_range(0, 7)), ($urandom_range(0, 9) == 0));
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(59610));
      rst_n   = 1'b0;
      raddr   = NONE;
      waddr   = NONE;
      ibus_in = '0;
      ir      = '0;
      ir_idx  = 1'b0;
      fp_rom  = 1'b0;
      cyc      = 0;
      err_rst  = 0;
      err_oe   = 0;
      err_bus  = 0;
      err_war  = 0;
      err_aext = 0;
      reset_model();
      repeat (3) exp_q.push_back('0);                    // Nothing comes out before the first command
      repeat (10) @(posedge clk4);
      #1;
      assert ({ibus_oe, war, ibus_out, aext} === '0) else begin
         err_rst++;
         $display("ERR %0t outputs not cleared during reset", $time);
      end
      rst_n = 1'b1;

      // Disabled, page default follows the switch
      fp_rom = 1'b1;
      apply_cmd(NONE, AR_0, 8'h00, 3'd3, 1'b0);
      idle_cycles(3);
      fp_rom = 1'b0;
      apply_cmd(NONE, AR_0, 8'h00, 3'd3, 1'b0);
      apply_cmd(UNIT_MBN, NONE, 8'h00, 3'd1, 1'b0);      // No bus drive yet
      apply_cmd(NONE, UNIT_MBP, 8'h55, 3'd0, 1'b0);      // Ignored while off
      apply_cmd(UNIT_MBP, NONE, 8'h00, 3'd0, 1'b0);
      // First MBn write, then read-before-write on slot 0
      apply_cmd(NONE, UNIT_MBN, 8'hA5, 3'd2, 1'b0);
      apply_cmd(UNIT_MBN, NONE, 8'h00, 3'd2, 1'b0);
      apply_cmd(NONE, UNIT_MBP, 8'h3C, 3'd0, 1'b0);
      apply_cmd(UNIT_MBP, UNIT_MBN, 8'h77, 3'd0, 1'b0);
      apply_cmd(UNIT_MBP, NONE, 8'h00, 3'd0, 1'b0);
      // Bank switch and CTX read back through both codes
      apply_cmd(NONE, UNIT_CTX_A, 8'h01, 3'd0, 1'b0);
      apply_cmd(NONE, UNIT_MBN, 8'h11, 3'd2, 1'b0);
      apply_cmd(UNIT_CTX_B, UNIT_CTX_B, 8'h00, 3'd0, 1'b0);
      apply_cmd(UNIT_MBN, NONE, 8'h00, 3'd2, 1'b0);
      apply_cmd(UNIT_CTX_A, NONE, 8'h00, 3'd0, 1'b0);
      // Write-AR by ir, then one by index
      apply_cmd(NONE, AR_0, 8'h00, 3'd2, 1'b0);
      apply_cmd(NONE, NONE, 8'h00, 3'd0, 1'b1);
      apply_cmd(IDX_2, AR_1, 8'h00, 3'd5, 1'b0);
      apply_cmd(IDX_2, AR_1, 8'h00, 3'd0, 1'b0);

      while (cyc < NUM_CYCLES)
         random_cmd();
      idle_cycles(3);                                    // Drain the delay line

      $display("Errors: reset %0d, ibus_oe %0d, ibus_out %0d, war %0d, aext %0d",
               err_rst, err_oe, err_bus, err_war, err_aext);
      if (err_rst + err_oe + err_bus + err_war + err_aext == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- tb.f
+incdir+tests
verilog/mbu_pkg.sv
verilog/mbu_if.sv
verilog/mbu_decoder.sv
verilog/mbu_control.sv
verilog/mbu_bank_file.sv
verilog/mbu.sv
tests/tb_mbu.sv

//--- run.sh
#!/bin/sh
# Build and run the MBU testbench with Verilator, pass only when the log says so
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_mbu -f tb.f -o tb_mbu_sim \
   && ./obj_dir/tb_mbu_sim > sim.log 2>&1 \
   || echo "Build or run error"
cat sim.log 2>/dev/null
grep -qx "Simulation passed" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
